//--- dmem_settings.svh
`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

// word address into the data space
`define DMEM_ADDR_W 16

// 64 lines of 4 words each
`define DMEM_INDEX_W 6
`define DMEM_OFFSET_W 2

// what is left of the address above index and offset
`define DMEM_TAG_W (`DMEM_ADDR_W - `DMEM_INDEX_W - `DMEM_OFFSET_W)

`define DMEM_DATA_W 32

`endif

//--- dmem_pkg.sv
`default_nettype none

`include "dmem_settings.svh"

package dmem_pkg;

    // core side load/store request
    typedef struct packed {
        logic                    rd;
        logic                    wr;
        logic [`DMEM_ADDR_W-1:0] addr;
        logic [`DMEM_DATA_W-1:0] wdata;
    } dmem_req_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`DMEM_ADDR_W-1:0] addr;
        logic [`DMEM_DATA_W-1:0] dat;
    } wb_m2s_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic                    ack;
        logic [`DMEM_DATA_W-1:0] dat;
    } wb_s2m_t;

    typedef enum logic {
        LINE_READ,
        LINE_WRITE
    } line_dir_e;

    // base is {tag, index} with the beat number below it
    typedef struct packed {
        logic                                  start;
        line_dir_e                             dir;
        logic [`DMEM_TAG_W+`DMEM_INDEX_W-1:0]  base;
    } line_cmd_t;

    typedef struct packed {
        logic                      valid;
        logic [`DMEM_OFFSET_W-1:0] num;
        logic [`DMEM_DATA_W-1:0]   data;
    } beat_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EVICT,
        ST_REFILL,
        ST_SETTLE
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- cache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module cache_tag_store (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`DMEM_INDEX_W-1:0] index,
    input  logic [`DMEM_TAG_W-1:0]   tag,
    input  logic                     fill,
    input  logic                     dirty_set,
    output logic                     hit,
    output logic [`DMEM_TAG_W-1:0]   victim_tag,
    output logic                     victim_dirty
);

    localparam int LINES = 1 << `DMEM_INDEX_W;

    logic [`DMEM_TAG_W-1:0] tags [LINES];
    logic [LINES-1:0]       valid;
    logic [LINES-1:0]       dirty;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (fill) begin
            // freshly filled line is clean
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;
        end else if (dirty_set) begin
            dirty[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[index] <= tag;
        end
    end

    assign hit          = valid[index] & (tags[index] == tag);
    assign victim_tag   = tags[index];
    assign victim_dirty = valid[index] & dirty[index];

endmodule

`default_nettype wire

//--- cache_line_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module cache_line_ram (
    input  logic                      clk,
    input  logic [`DMEM_INDEX_W-1:0]  index,
    input  logic [`DMEM_OFFSET_W-1:0] word,
    input  logic                      wr_en,
    input  logic [`DMEM_DATA_W-1:0]   wr_data,
    output logic [`DMEM_DATA_W-1:0]   rd_data
);

    localparam int LINES = 1 << `DMEM_INDEX_W;
    localparam int WORDS = 1 << `DMEM_OFFSET_W;

    logic [`DMEM_DATA_W-1:0]   bank_rd [WORDS];
    logic [`DMEM_OFFSET_W-1:0] word_q;

    // one bank per word position in the line
    for (genvar b = 0; b < WORDS; b++) begin : g_bank
        logic [`DMEM_DATA_W-1:0] mem [LINES];
        logic [`DMEM_DATA_W-1:0] rd_q;
        logic                    sel;

        assign sel = (word == b[`DMEM_OFFSET_W-1:0]);

        always_ff @(posedge clk) begin
            if (wr_en && sel) begin
                mem[index] <= wr_data;
            end
            // read-before-write on a same cycle access
            rd_q <= mem[index];
        end

        assign bank_rd[b] = rd_q;
    end

    always_ff @(posedge clk) begin
        word_q <= word;
    end

    // word picked in the same cycle as the bank read
    assign rd_data = bank_rd[word_q];

endmodule

`default_nettype wire

//--- wb_line_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module wb_line_master import dmem_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  line_cmd_t                 cmd,
    input  logic [`DMEM_DATA_W-1:0]   wr_word,
    output beat_t                     beat,
    output logic [`DMEM_OFFSET_W-1:0] next_beat,
    output logic                      done,
    output wb_m2s_t                   wbm,
    input  wb_s2m_t                   wbs
);

    logic                                 cyc_q;
    logic                                 stb_q;
    logic                                 we_q;
    logic [`DMEM_OFFSET_W-1:0]            cnt_q;
    logic [`DMEM_TAG_W+`DMEM_INDEX_W-1:0] base_q;
    logic                                 ack_beat;
    logic                                 last;

    assign ack_beat = stb_q & wbs.ack;
    assign last     = (cnt_q == '1);

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
            we_q  <= 1'b0;
            cnt_q <= '0;
        end else if (!cyc_q) begin
            if (cmd.start) begin
                cyc_q <= 1'b1;
                stb_q <= 1'b1;
                we_q  <= (cmd.dir == LINE_WRITE);
                cnt_q <= '0;
            end
        end else if (ack_beat) begin
            // counter wraps back to 0 after the last beat
            cnt_q <= cnt_q + 1'b1;
            if (last) begin
                cyc_q <= 1'b0;
                stb_q <= 1'b0;
            end else begin
                // writes skip a cycle so the ram read catches up
                stb_q <= ~we_q;
            end
        end else if (!stb_q) begin
            stb_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!cyc_q && cmd.start) begin
            base_q <= cmd.base;
        end
    end

    always_comb begin
        wbm.cyc    = cyc_q;
        wbm.stb    = stb_q;
        wbm.we     = we_q;
        wbm.addr   = {base_q, cnt_q};
        wbm.dat    = wr_word;
        beat.valid = ack_beat;
        beat.num   = cnt_q;
        beat.data  = wbs.dat;
    end

    assign next_beat = cnt_q;
    assign done      = ack_beat & last;

endmodule

`default_nettype wire

//--- dmem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module dmem_ctrl import dmem_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  dmem_req_t                 req,
    output logic                      stall,
    input  logic                      hit,
    input  logic                      victim_dirty,
    input  logic [`DMEM_TAG_W-1:0]    victim_tag,
    output logic                      tag_fill,
    output logic                      tag_dirty_set,
    output logic [`DMEM_OFFSET_W-1:0] ram_word,
    output logic                      ram_wr_en,
    output logic [`DMEM_DATA_W-1:0]   ram_wr_data,
    output line_cmd_t                 cmd,
    input  beat_t                     beat,
    input  logic [`DMEM_OFFSET_W-1:0] next_beat,
    input  logic                      done
);

    logic [`DMEM_TAG_W-1:0]    req_tag;
    logic [`DMEM_INDEX_W-1:0]  req_index;
    logic [`DMEM_OFFSET_W-1:0] req_word;
    logic                      active;
    ctrl_state_e               state;

    assign {req_tag, req_index, req_word} = req.addr;
    assign active = req.rd | req.wr;

    // a miss stalls in the same cycle and any transfer keeps it up
    assign stall = (state != ST_IDLE) | (active & ~hit);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cmd   <= '0;
        end else begin
            // start is a single cycle pulse
            cmd.start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (active && !hit) begin
                        cmd.start <= 1'b1;
                        if (victim_dirty) begin
                            // write the old line back first
                            state    <= ST_EVICT;
                            cmd.dir  <= LINE_WRITE;
                            cmd.base <= {victim_tag, req_index};
                        end else begin
                            state    <= ST_REFILL;
                            cmd.dir  <= LINE_READ;
                            cmd.base <= {req_tag, req_index};
                        end
                    end
                end
                ST_EVICT: begin
                    if (done) begin
                        state     <= ST_REFILL;
                        cmd.start <= 1'b1;
                        cmd.dir   <= LINE_READ;
                        cmd.base  <= {req_tag, req_index};
                    end
                end
                ST_REFILL: begin
                    if (done) begin
                        state <= ST_SETTLE;
                    end
                end
                ST_SETTLE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ram and tag steering
    always_comb begin
        tag_fill      = 1'b0;
        tag_dirty_set = 1'b0;
        ram_word      = req_word;
        ram_wr_en     = 1'b0;
        ram_wr_data   = req.wdata;
        case (state)
            ST_IDLE: begin
                ram_wr_en     = req.wr & hit;
                tag_dirty_set = req.wr & hit;
            end
            ST_EVICT: begin
                // fetch ahead for the master's next write beat
                ram_word = next_beat;
            end
            ST_REFILL: begin
                ram_word    = beat.num;
                ram_wr_en   = beat.valid;
                ram_wr_data = beat.data;
                // line is complete with the last beat
                tag_fill    = done;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- dmem_system.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module dmem_system import dmem_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  dmem_req_t               req,
    output logic                    stall,
    output logic [`DMEM_DATA_W-1:0] rdata,
    output wb_m2s_t                 wbm,
    input  wb_s2m_t                 wbs
);

    logic [`DMEM_TAG_W-1:0]    req_tag;
    logic [`DMEM_INDEX_W-1:0]  req_index;
    logic                      hit;
    logic                      victim_dirty;
    logic [`DMEM_TAG_W-1:0]    victim_tag;
    logic                      tag_fill;
    logic                      tag_dirty_set;
    logic [`DMEM_OFFSET_W-1:0] ram_word;
    logic                      ram_wr_en;
    logic [`DMEM_DATA_W-1:0]   ram_wr_data;
    line_cmd_t                 cmd;
    beat_t                     beat;
    logic [`DMEM_OFFSET_W-1:0] next_beat;
    logic                      done;

    // address split into tag, index and word
    assign req_tag   = req.addr[`DMEM_ADDR_W-1 -: `DMEM_TAG_W];
    assign req_index = req.addr[`DMEM_OFFSET_W +: `DMEM_INDEX_W];

    dmem_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .stall         (stall),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .tag_fill      (tag_fill),
        .tag_dirty_set (tag_dirty_set),
        .ram_word      (ram_word),
        .ram_wr_en     (ram_wr_en),
        .ram_wr_data   (ram_wr_data),
        .cmd           (cmd),
        .beat          (beat),
        .next_beat     (next_beat),
        .done          (done)
    );

    cache_tag_store u_tags (
        .clk          (clk),
        .rst          (rst),
        .index        (req_index),
        .tag          (req_tag),
        .fill         (tag_fill),
        .dirty_set    (tag_dirty_set),
        .hit          (hit),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    // ram output feeds both the core and the write-back path
    cache_line_ram u_ram (
        .clk     (clk),
        .index   (req_index),
        .word    (ram_word),
        .wr_en   (ram_wr_en),
        .wr_data (ram_wr_data),
        .rd_data (rdata)
    );

    wb_line_master u_master (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .wr_word   (rdata),
        .beat      (beat),
        .next_beat (next_beat),
        .done      (done),
        .wbm       (wbm),
        .wbs       (wbs)
    );

endmodule

`default_nettype wire

//--- wb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module wb_mem_model import dmem_pkg::*; #(
    parameter logic [31:0]             SEED     = 32'h1,
    parameter logic [`DMEM_DATA_W-1:0] FILL_KEY = '0
) (
    input  logic    clk,
    input  logic    rst,
    input  wb_m2s_t wbm,
    output wb_s2m_t wbs
);

    localparam int WORDS = 1 << `DMEM_ADDR_W;

    logic [`DMEM_DATA_W-1:0] mem [WORDS];
    logic [`DMEM_DATA_W-1:0] dat_q;
    logic [1:0]              wait_q;
    logic                    ack_q;
    integer                  delay_seed;

    initial begin
        logic [`DMEM_ADDR_W-1:0] a;
        delay_seed = SEED;
        for (int i = 0; i < WORDS; i++) begin
            a = i;
            mem[i] = {a, a} ^ FILL_KEY;
        end
    end

    // ack is registered, so each beat takes at least one wait cycle
    always @(posedge clk) begin
        if (rst) begin
            ack_q  <= 1'b0;
            wait_q <= 2'd0;
            dat_q  <= '0;
        end else begin
            ack_q <= 1'b0;
            if (wbm.cyc && wbm.stb && !ack_q) begin
                if (wait_q != 2'd0) begin
                    wait_q <= wait_q - 2'd1;
                end else begin
                    ack_q  <= 1'b1;
                    // delay for the next beat, 0 to 3 cycles
                    wait_q <= $random(delay_seed) & 3;
                    if (wbm.we) begin
                        mem[wbm.addr] <= wbm.dat;
                    end else begin
                        dat_q <= mem[wbm.addr];
                    end
                end
            end
        end
    end

    assign wbs = {ack_q, dat_q};

endmodule

`default_nettype wire

//--- tb_dmem_system.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module tb_dmem_system import dmem_pkg::*; ();

    localparam int AW          = `DMEM_ADDR_W;
    localparam int DW          = `DMEM_DATA_W;
    localparam int TW          = `DMEM_TAG_W;
    localparam int IW          = `DMEM_INDEX_W;
    localparam int OW          = `DMEM_OFFSET_W;
    localparam int N_RANDOM    = 400;
    localparam int N_DIRECTED  = 16;
    // two lines of four beats at about five cycles a beat
    localparam int MISS_CYCLES = 2 * 4 * 5;
    localparam int LIMIT       = (N_RANDOM + N_DIRECTED) * (MISS_CYCLES + 20) + 200;
    localparam logic [DW-1:0] FILL_KEY = 32'h6b2d_c4e1;

    logic          clk = 1'b0;
    logic          rst;
    dmem_req_t     req;
    logic          stall;
    logic [DW-1:0] rdata;
    wb_m2s_t       wbm;
    wb_s2m_t       wbs;

    logic [DW-1:0] ref_mem [1 << AW];
    integer        seed;
    int            cycles = 0;
    int            pass_count = 0;
    int            fail_count = 0;

    always #5 clk = ~clk;

    dmem_system DUT (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .stall (stall),
        .rdata (rdata),
        .wbm   (wbm),
        .wbs   (wbs)
    );

    wb_mem_model #(
        .SEED     (32'h8cd0d57c),
        .FILL_KEY (FILL_KEY)
    ) mem_model (
        .clk (clk),
        .rst (rst),
        .wbm (wbm),
        .wbs (wbs)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("timeout: the run hung, no result after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [AW-1:0] make_addr(input logic [TW-1:0] tag,
                                                input logic [IW-1:0] index,
                                                input logic [OW-1:0] word);
        return {tag, index, word};
    endfunction

    task automatic check_word(input string name, input logic [DW-1:0] expected,
                              input logic [DW-1:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            fail_count++;
        end else begin
            $display("ok    %s %h", name, actual);
            pass_count++;
        end
    endtask

    task automatic check_bus_word(input string name, input logic [AW-1:0] addr,
                                  input logic [DW-1:0] expected);
        logic [DW-1:0] actual;
        actual = mem_model.mem[addr];
        check_word(name, expected, actual);
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s expected %b actual %b", name, expected, actual);
            fail_count++;
        end else begin
            $display("ok    %s %b", name, actual);
            pass_count++;
        end
    endtask

    // hold one request until stall falls and take rdata one cycle later
    task automatic access(input logic rd, input logic wr, input logic [AW-1:0] addr,
                          input logic [DW-1:0] wdata, output logic [DW-1:0] data,
                          output logic stalled);
        dmem_req_t r;
        r.rd    = rd;
        r.wr    = wr;
        r.addr  = addr;
        r.wdata = wdata;
        @(posedge clk);
        req <= r;
        @(negedge clk);
        stalled = stall;
        while (stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        data = rdata;
    endtask

    task automatic write_word(input logic [AW-1:0] addr, input logic [DW-1:0] value);
        logic [DW-1:0] data;
        logic          stalled;
        access(1'b0, 1'b1, addr, value, data, stalled);
        ref_mem[addr] = value;
    endtask

    task automatic read_word(input string name, input logic [AW-1:0] addr,
                             output logic stalled);
        logic [DW-1:0] data;
        access(1'b1, 1'b0, addr, '0, data, stalled);
        check_word(name, ref_mem[addr], data);
    endtask

    initial begin
        logic [AW-1:0] a;
        logic [AW-1:0] b;
        logic [DW-1:0] r;
        logic          stalled;
        seed = 32'h8cd0d57c;
        rst  = 1'b1;
        req  = '0;
        for (int i = 0; i < (1 << AW); i++) begin
            a = i;
            ref_mem[i] = {a, a} ^ FILL_KEY;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("reset stall", 1'b0, stall);
        check_bit("reset cyc", 1'b0, wbm.cyc);
        check_bit("reset stb", 1'b0, wbm.stb);

        // cold reads see the memory preset
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            read_word($sformatf("cold read %h", r[AW-1:0]), r[AW-1:0], stalled);
        end

        // write then read back on a hit
        for (int i = 0; i < 2; i++) begin
            a = make_addr(8'h30 + i, 6'h0c + i, 2'(i));
            write_word(a, $random(seed));
            read_word($sformatf("read after write %h", a), a, stalled);
            check_bit($sformatf("hit stall %h", a), 1'b0, stalled);
        end

        // same index and other tag so the dirty line goes back to memory
        a = make_addr(8'h40, 6'h2a, 2'd1);
        b = make_addr(8'h41, 6'h2a, 2'd3);
        write_word(a, $random(seed));
        read_word($sformatf("conflict read %h", b), b, stalled);
        check_bus_word($sformatf("write-back %h", a), a, ref_mem[a]);
        read_word($sformatf("reload %h", a), a, stalled);

        // three tags on four indexes
        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            a = make_addr(8'h21 + 8'h3b * (r[1:0] % 3), {r[3:2], 4'h5}, r[5:4]);
            if (r[6]) begin
                write_word(a, $random(seed));
            end else begin
                read_word($sformatf("random %0d %h", i, a), a, stalled);
            end
        end

        $display("checks %0d passed %0d failed %0d", pass_count + fail_count,
                 pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dmem_system.f
+incdir+.
dmem_pkg.sv
cache_tag_store.sv
cache_line_ram.sv
wb_line_master.sv
dmem_ctrl.sv
dmem_system.sv
wb_mem_model.sv
tb_dmem_system.sv
